//--- verilog.f
common/err_capture_pkg.sv
common/error_tracker_debug_intf.sv
error_tracker/capture_sram.sv
error_tracker/error_tracker.sv
hw/error_trigger.sv
hw/debug_readout.sv
hw/err_capture_top.sv
test/tb_err_capture.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_err_capture \
	-f verilog.f -o tb_err_capture || { echo "build failed"; exit 1; }

output="$(./obj_dir/tb_err_capture)"
echo "$output"
grep -q "RESULT: PASS" <<< "$output" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- test/tb_err_capture.sv
`timescale 1ns/1ns

module tb_err_capture
	import err_capture_pkg::*;
();

	localparam int clk_half = 10;
	localparam int reset_cycles = 5;
	localparam int max_cycles = 6000; // Tests need about 2500.
	localparam int wait_limit = 20;
	localparam int test_threshold = 40;
	localparam int quiet_limit = test_threshold - 1; // Largest magnitude that must not fire.
	localparam int slot_count = 8;

	logic clk = 1'b0;
	logic rstb;
	logic signed [error_width-1:0] errors [total_lanes];
	logic [total_lanes-1:0] prbs_flags;
	logic [total_lanes-1:0] bitstream;
	logic [1:0] sd_flags [total_lanes];
	logic [threshold_width-1:0] threshold;
	logic [frame_addr_width-1:0] dbg_addr;
	logic [2:0] dbg_word_sel;
	logic dbg_read;
	logic dbg_clear;
	logic [word_width-1:0] dbg_data;
	logic [stored_count_width-1:0] dbg_stored_frames;
	logic dbg_done;

	// Recorded input samples, one slot per triggering cycle.
	logic [total_lanes*error_width-1:0] snap_err [slot_count];
	logic [total_lanes-1:0] snap_prbs [slot_count];
	logic [total_lanes-1:0] snap_bits [slot_count];
	logic [2*total_lanes-1:0] snap_sd [slot_count];

	logic [31:0] rng_state = 32'h17ae_d63d;
	int cycle_count = 0;
	int check_count = 0;
	int error_count = 0;

	err_capture_top DUT (
		.clk(clk),
		.rstb(rstb),
		.errors(errors),
		.prbs_flags(prbs_flags),
		.bitstream(bitstream),
		.sd_flags(sd_flags),
		.threshold(threshold),
		.dbg_addr(dbg_addr),
		.dbg_word_sel(dbg_word_sel),
		.dbg_read(dbg_read),
		.dbg_clear(dbg_clear),
		.dbg_data(dbg_data),
		.dbg_stored_frames(dbg_stored_frames),
		.dbg_done(dbg_done)
	);

	always #clk_half clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == max_cycles) begin
			$display("timeout, run stopped after %0d cycles", max_cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Frame layout built from the recorded sample, then cut into readout words.
	function automatic logic [31:0] expected_word(input int slot, input int frame, input int word);
		logic [frame_width-1:0] f;
		f = '0;
		if (frame < group_count) begin
			for (int k = 0; k < lane_count; k++) begin
				f[k*8 +: 8] = snap_err[slot][(frame*lane_count + k)*8 +: 8];
			end
		end else begin
			f[47:0] = snap_prbs[slot];
			f[95:48] = snap_bits[slot];
			for (int k = 0; k < sd_stored_lanes; k++) begin
				f[96 + 2*k +: 2] = snap_sd[slot][(sd_first_lane + k)*2 +: 2];
			end
		end
		if (word < 4) begin
			return f[word*32 +: 32];
		end
		return {16'hffff, f[143:128]}; // Selects above 4 alias to word 4.
	endfunction

	// Random sample that stays below the threshold.
	task automatic drive_quiet();
		logic [31:0] r;
		for (int i = 0; i < total_lanes; i++) begin
			r = next_random();
			errors[i] = error_width'(int'(r % 32'(2*quiet_limit + 1)) - quiet_limit);
			sd_flags[i] = r[31:30];
		end
		prbs_flags = '0;
		r = next_random();
		bitstream[31:0] = r;
		r = next_random();
		bitstream[47:32] = r[15:0];
	endtask

	task automatic quiet_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			drive_quiet();
		end
	endtask

	task automatic record_snapshot(input int slot);
		for (int i = 0; i < total_lanes; i++) begin
			snap_err[slot][i*8 +: 8] = errors[i];
			snap_sd[slot][i*2 +: 2] = sd_flags[i];
		end
		snap_prbs[slot] = prbs_flags;
		snap_bits[slot] = bitstream;
	endtask

	// Kind 0 sets a PRBS flag, 1 a lone error at minus threshold, 2 at plus threshold.
	task automatic trigger_cycle(input int kind, input int slot);
		logic [31:0] r;
		@(negedge clk);
		drive_quiet();
		r = next_random();
		case (kind)
			0: prbs_flags[r % 48] = 1'b1;
			1: errors[r % 48] = error_width'(-test_threshold);
			default: errors[r % 48] = error_width'(test_threshold);
		endcase
		record_snapshot(slot);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		check_count++;
		assert (got == exp) else begin
			$display("ERROR %s exp %h got %h", name, exp, got);
			error_count++;
		end
	endtask

	task automatic wait_count(input int target);
		int n;
		n = 0;
		while (dbg_stored_frames != stored_count_width'(target) && n < wait_limit) begin
			@(negedge clk);
			drive_quiet();
			n++;
		end
		check_value("dbg_stored_frames", 32'(target), 32'(dbg_stored_frames));
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (!dbg_done && n < wait_limit) begin
			@(negedge clk);
			drive_quiet();
			n++;
		end
		check_count++;
		assert (dbg_done) else begin
			$display("dbg_done did not rise within %0d cycles", wait_limit);
			error_count++;
		end
	endtask

	task automatic read_word(input int addr, input int sel, output logic [31:0] data);
		@(negedge clk);
		dbg_addr = frame_addr_width'(addr);
		dbg_word_sel = 3'(sel);
		repeat (3) @(negedge clk); // Select register, memory read, output register.
		data = dbg_data;
	endtask

	task automatic check_event(input int slot, input int base);
		logic [31:0] got;
		logic [31:0] exp;
		for (int f = 0; f < frames_per_event; f++) begin
			for (int w = 0; w < words_per_frame; w++) begin
				read_word(base + f, w, got);
				exp = expected_word(slot, f, w);
				check_count++;
				assert (got == exp) else begin
					$display("ERROR dbg_data addr %h word %h exp %h got %h", base + f, w, exp, got);
					error_count++;
				end
			end
		end
	endtask

	task automatic rearm();
		@(negedge clk);
		dbg_read = 1'b0;
		dbg_clear = 1'b1;
		drive_quiet();
		@(negedge clk);
		dbg_clear = 1'b0;
		check_value("dbg_done", 32'd0, 32'(dbg_done));
	endtask

	task automatic report_test(input int num, input string name, input int errors_before);
		$display("test %0d %s: %s", num, name, (error_count == errors_before) ? "ok" : "failed");
	endtask

	initial begin
		int errors_before;
		logic [31:0] got;
		logic [31:0] exp;
		rstb = 1'b0;
		for (int i = 0; i < total_lanes; i++) begin
			errors[i] = '0;
			sd_flags[i] = '0;
		end
		prbs_flags = '0;
		bitstream = '0;
		threshold = threshold_width'(test_threshold);
		dbg_addr = '0;
		dbg_word_sel = '0;
		dbg_read = 1'b0;
		dbg_clear = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rstb = 1'b1;

		errors_before = error_count;
		quiet_cycles(10);
		trigger_cycle(0, 0);
		wait_count(4);
		@(negedge clk);
		dbg_read = 1'b1;
		wait_done();
		check_value("dbg_stored_frames", 32'd4, 32'(dbg_stored_frames));
		check_event(0, 0);
		report_test(1, "single capture", errors_before);

		errors_before = error_count;
		rearm();
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			drive_quiet();
			errors[i % total_lanes] = error_width'(quiet_limit); // Just below the threshold.
			errors[(i + 24) % total_lanes] = error_width'(-quiet_limit);
		end
		quiet_cycles(3);
		check_value("dbg_stored_frames", 32'd0, 32'(dbg_stored_frames));
		trigger_cycle(1, 1);
		wait_count(4);
		trigger_cycle(2, 2);
		wait_count(8);
		@(negedge clk);
		dbg_read = 1'b1;
		wait_done();
		check_event(1, 0);
		check_event(2, 4);
		report_test(2, "threshold rule", errors_before);

		errors_before = error_count;
		rearm();
		quiet_cycles(5);
		trigger_cycle(0, 3);
		quiet_cycles(1);
		trigger_cycle(0, 4); // Lands while the first event is storing.
		wait_count(4);
		quiet_cycles(10);
		check_value("dbg_stored_frames", 32'd4, 32'(dbg_stored_frames));
		@(negedge clk);
		dbg_read = 1'b1;
		wait_done();
		check_event(3, 0);
		report_test(3, "trigger during store", errors_before);

		errors_before = error_count;
		rearm();
		for (int i = 0; i < 16; i++) begin
			quiet_cycles(2);
			trigger_cycle(i % 3, 5); // Slot keeps the latest event.
			wait_count(4 * (i + 1));
		end
		trigger_cycle(0, 6);
		quiet_cycles(10);
		check_value("dbg_done", 32'd1, 32'(dbg_done));
		check_value("dbg_stored_frames", 32'd64, 32'(dbg_stored_frames));
		check_event(5, 60);
		report_test(4, "memory full", errors_before);

		errors_before = error_count;
		@(negedge clk);
		dbg_clear = 1'b1;
		@(negedge clk);
		dbg_clear = 1'b0;
		check_value("dbg_done", 32'd0, 32'(dbg_done));
		check_value("dbg_stored_frames", 32'd0, 32'(dbg_stored_frames));
		quiet_cycles(3);
		trigger_cycle(2, 7);
		wait_count(4);
		@(negedge clk);
		dbg_read = 1'b1;
		wait_done();
		check_event(7, 0);
		report_test(5, "clear and rearm", errors_before);

		errors_before = error_count;
		for (int f = 0; f < frames_per_event; f++) begin
			read_word(f, 4, got);
			check_count++;
			assert (got[31:16] == 16'hffff) else begin
				$display("ERROR dbg_data[31:16] addr %h exp ffff got %h", f, got[31:16]);
				error_count++;
			end
			read_word(f, 7, got);
			exp = expected_word(7, f, 4);
			check_count++;
			assert (got == exp) else begin
				$display("ERROR dbg_data addr %h word 7 exp %h got %h", f, exp, got);
				error_count++;
			end
		end
		report_test(6, "word padding", errors_before);

		$display("tests run 6, checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule : tb_err_capture

//--- hw/err_capture_top.sv
`timescale 1ns/1ns

module err_capture_top
	import err_capture_pkg::*;
(
	input logic clk,
	input logic rstb,

	input logic signed [error_width-1:0] errors [total_lanes],
	input logic [total_lanes-1:0] prbs_flags,
	input logic [total_lanes-1:0] bitstream,
	input logic [1:0] sd_flags [total_lanes],
	input logic [threshold_width-1:0] threshold,

	input logic [frame_addr_width-1:0] dbg_addr,
	input logic [2:0] dbg_word_sel,
	input logic dbg_read,
	input logic dbg_clear,
	output logic [word_width-1:0] dbg_data,
	output logic [stored_count_width-1:0] dbg_stored_frames,
	output logic dbg_done
);

	logic trig;
	logic signed [error_width-1:0] errors_q [total_lanes];
	logic [total_lanes-1:0] prbs_q;
	logic [total_lanes-1:0] bits_q;
	logic [1:0] sd_q [total_lanes];

	error_tracker_debug_intf dbg_if ();

	error_trigger u_error_trigger (
		.clk(clk),
		.rstb(rstb),
		.errors(errors),
		.prbs_flags(prbs_flags),
		.bitstream(bitstream),
		.sd_flags(sd_flags),
		.threshold(threshold),
		.trig(trig),
		.errors_q(errors_q),
		.prbs_q(prbs_q),
		.bits_q(bits_q),
		.sd_q(sd_q)
	);

	error_tracker u_error_tracker (
		.clk(clk),
		.rstb(rstb),
		.trig(trig),
		.errors_q(errors_q),
		.prbs_q(prbs_q),
		.bits_q(bits_q),
		.sd_q(sd_q),
		.dbg(dbg_if.tracker)
	);

	debug_readout u_debug_readout (
		.clk(clk),
		.rstb(rstb),
		.dbg_addr(dbg_addr),
		.dbg_word_sel(dbg_word_sel),
		.dbg_read(dbg_read),
		.dbg_clear(dbg_clear),
		.dbg_data(dbg_data),
		.dbg_stored_frames(dbg_stored_frames),
		.dbg_done(dbg_done),
		.trk(dbg_if.readout)
	);

endmodule : err_capture_top

//--- hw/debug_readout.sv
`timescale 1ns/1ns

module debug_readout
	import err_capture_pkg::*;
(
	input logic clk,
	input logic rstb,

	input logic [frame_addr_width-1:0] dbg_addr,
	input logic [2:0] dbg_word_sel,
	input logic dbg_read,
	input logic dbg_clear,
	output logic [word_width-1:0] dbg_data,
	output logic [stored_count_width-1:0] dbg_stored_frames,
	output logic dbg_done,

	error_tracker_debug_intf.readout trk
);

	localparam int last_word = words_per_frame - 1;
	localparam int pad_width = word_width * words_per_frame - frame_width;

	logic [frame_addr_width-1:0] addr_q;
	logic [2:0] sel_q;
	logic [2:0] sel_qq; // Lines up with the memory read data.
	logic [word_width-1:0] words [words_per_frame];
	logic [2:0] sel_eff;

	genvar gi;
	generate
		for (gi = 0; gi < last_word; gi++) begin : g_word
			assign words[gi] = trk.frame_data[gi*word_width +: word_width];
		end
	endgenerate

	// Top word carries the leftover bits, padded with ones.
	assign words[last_word] = {{pad_width{1'b1}}, trk.frame_data[frame_width-1:last_word*word_width]};

	assign sel_eff = (sel_qq > 3'(last_word)) ? 3'(last_word) : sel_qq;

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			addr_q <= '0;
			sel_q <= '0;
			sel_qq <= '0;
			dbg_data <= '0;
		end else begin
			addr_q <= dbg_addr;
			sel_q <= dbg_word_sel;
			sel_qq <= sel_q;
			dbg_data <= words[sel_eff];
		end
	end

	assign trk.addr = addr_q;
	assign trk.read = dbg_read;
	assign trk.clear = dbg_clear;

	assign dbg_stored_frames = trk.stored_frames;
	assign dbg_done = trk.done;

endmodule : debug_readout

//--- hw/error_trigger.sv
`timescale 1ns/1ns

module error_trigger
	import err_capture_pkg::*;
(
	input logic clk,
	input logic rstb,

	input logic signed [error_width-1:0] errors [total_lanes],
	input logic [total_lanes-1:0] prbs_flags,
	input logic [total_lanes-1:0] bitstream,
	input logic [1:0] sd_flags [total_lanes],
	input logic [threshold_width-1:0] threshold,

	output logic trig,
	output logic signed [error_width-1:0] errors_q [total_lanes],
	output logic [total_lanes-1:0] prbs_q,
	output logic [total_lanes-1:0] bits_q,
	output logic [1:0] sd_q [total_lanes]
);

	logic [error_width-1:0] mag [total_lanes];
	logic [total_lanes-1:0] over;
	logic hit;

	// Unsigned magnitude, so -128 reads as 128.
	always_comb begin
		for (int i = 0; i < total_lanes; i++) begin
			mag[i] = errors[i][error_width-1] ? -errors[i] : errors[i];
			over[i] = (mag[i] >= error_width'(threshold)); // Zero threshold always fires.
		end
	end

	assign hit = (|over) || (|prbs_flags);

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			trig <= 1'b0;
		end else begin
			trig <= hit;
		end
	end

	// Data registered alongside the trigger so both line up.
	always_ff @(posedge clk) begin
		errors_q <= errors;
		prbs_q <= prbs_flags;
		bits_q <= bitstream;
		sd_q <= sd_flags;
	end

endmodule : error_trigger

//--- error_tracker/error_tracker.sv
`timescale 1ns/1ns

module error_tracker
	import err_capture_pkg::*;
(
	input logic clk,
	input logic rstb,

	input logic trig,
	input logic signed [error_width-1:0] errors_q [total_lanes],
	input logic [total_lanes-1:0] prbs_q,
	input logic [total_lanes-1:0] bits_q,
	input logic [1:0] sd_q [total_lanes],

	error_tracker_debug_intf.tracker dbg
);

	localparam int flag_frame = frames_per_event - 1; // Index of the PRBS and detector frame.
	localparam int error_bits = lane_count * error_width;
	localparam int sd_base = 2 * total_lanes; // Detector bits start above PRBS and bitstream.

	tracker_state_t state;

	logic [frame_width-1:0] next_frames [frames_per_event];
	logic [frame_width-1:0] snap [frames_per_event];

	logic [1:0] store_count;
	logic [stored_count_width-1:0] frame_count;
	logic [frame_addr_width-1:0] wr_addr;
	logic [frame_addr_width-1:0] mem_addr;
	logic [frame_width-1:0] mem_rdata;
	logic we;
	logic last_frame;
	logic at_end;

	genvar gg, gj, gk;
	generate
		for (gg = 0; gg < group_count; gg++) begin : g_err_frame
			for (gj = 0; gj < lane_count; gj++) begin : g_lane
				// Two's complement byte per lane.
				assign next_frames[gg][gj*error_width +: error_width] =
					$unsigned(errors_q[gg*lane_count + gj]);
			end
			assign next_frames[gg][frame_width-1:error_bits] = '0; // Unused top bits.
		end

		assign next_frames[flag_frame][total_lanes-1:0] = prbs_q;
		assign next_frames[flag_frame][sd_base-1:total_lanes] = bits_q;
		for (gk = 0; gk < sd_stored_lanes; gk++) begin : g_sd
			assign next_frames[flag_frame][sd_base + 2*gk +: 2] = sd_q[sd_first_lane + gk];
		end
	endgenerate

	assign wr_addr = frame_count[frame_addr_width-1:0];
	assign last_frame = (store_count == 2'(flag_frame));
	assign at_end = &wr_addr; // Writing the last entry.

	// Debug address takes over the memory once capture has stopped.
	assign mem_addr = (state == done) ? dbg.addr : wr_addr;

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			state <= ready;
			we <= 1'b0;
			store_count <= '0;
			frame_count <= '0;
		end else begin
			case (state)
				ready: begin
					if (trig) begin
						state <= store;
						we <= 1'b1; // First write on the next edge.
						store_count <= '0;
					end else if (dbg.read) begin
						state <= done;
					end
				end
				store: begin
					frame_count <= frame_count + 1'b1;
					if (last_frame || at_end) begin
						we <= 1'b0;
						store_count <= '0;
						state <= (dbg.read || at_end) ? done : ready;
					end else begin
						store_count <= store_count + 1'b1;
					end
				end
				done: begin
					if (dbg.clear) begin
						state <= ready;
						frame_count <= '0;
					end
				end
				default: begin
					state <= ready;
					we <= 1'b0;
				end
			endcase
		end
	end

	// Frozen copy of the triggering sample, held while storing.
	always_ff @(posedge clk) begin
		if (state == ready && trig) begin
			for (int i = 0; i < frames_per_event; i++) begin
				snap[i] <= next_frames[i];
			end
		end
	end

	capture_sram u_capture_sram (
		.clk(clk),
		.we(we),
		.addr(mem_addr),
		.wdata(snap[store_count]),
		.rdata(mem_rdata)
	);

	assign dbg.frame_data = mem_rdata;
	assign dbg.stored_frames = frame_count;
	assign dbg.done = (state == done);

endmodule : error_tracker

//--- error_tracker/capture_sram.sv
`timescale 1ns/1ns

module capture_sram
	import err_capture_pkg::*;
(
	input logic clk,
	input logic we,
	input logic [frame_addr_width-1:0] addr,
	input logic [frame_width-1:0] wdata,
	output logic [frame_width-1:0] rdata
);

	localparam int depth = 2 ** frame_addr_width;

	logic [frame_width-1:0] mem [depth];

	// Single port, read data one cycle after the address.
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr]; // Old contents on a write cycle.
	end

endmodule : capture_sram

//--- common/error_tracker_debug_intf.sv
`timescale 1ns/1ns

interface error_tracker_debug_intf
	import err_capture_pkg::*;
();

	logic [frame_addr_width-1:0] addr; // Frame to read while done.
	logic read; // Level, stops capturing.
	logic clear; // One-cycle pulse, rearms.

	logic [frame_width-1:0] frame_data;
	logic [stored_count_width-1:0] stored_frames;
	logic done;

	modport tracker (
		input addr,
		input read,
		input clear,
		output frame_data,
		output stored_frames,
		output done
	);

	modport readout (
		output addr,
		output read,
		output clear,
		input frame_data,
		input stored_frames,
		input done
	);

endinterface : error_tracker_debug_intf

//--- common/err_capture_pkg.sv
package err_capture_pkg;

	// Lane organisation of the equalizer error inputs.
	localparam int lane_count = 16; // Lanes per group.
	localparam int group_count = 3;
	localparam int total_lanes = lane_count * group_count;

	localparam int error_width = 8; // Signed slicer error.
	localparam int threshold_width = 7;

	// Capture memory geometry.
	localparam int frame_width = 144;
	localparam int frames_per_event = 4; // Three error frames and one flag frame.
	localparam int frame_addr_width = 6;
	localparam int stored_count_width = frame_addr_width + 1; // Holds a full count of 64.

	// Sliding detector lanes that fit in the flag frame.
	localparam int sd_first_lane = 8;
	localparam int sd_stored_lanes = 24;

	// Debug readout chunking.
	localparam int word_width = 32;
	localparam int words_per_frame = 5;

	typedef enum logic [1:0] {
		ready,
		store,
		done
	} tracker_state_t;

endpackage : err_capture_pkg
